// ==== compile.f ====
+incdir+include
src/ExPkg.sv
src/ExMulW.sv
src/ExAluW.sv
src/ExShiftW.sv
src/ExUnit.sv
tb/tbExUnit.sv

// ==== include/ExUnit_defs.svh ====
// Width and fill constants for the execute stage; only a 64-bit data width is supported.
`ifndef EX_UNIT_DEFS_SVH
`define EX_UNIT_DEFS_SVH

// ~~~~~~~~~~~~~~~~~~~~
// Data width
// ~~~~~~~~~~~~~~~~~~~~

`define EX_DATA_W	64

// ~~~~~~~~~~~~~~~~~~~~
// Fill constants
// ~~~~~~~~~~~~~~~~~~~~

`define UV16_00		16'h0000
`define UV16_FF		16'hFFFF

`define UV32_00		32'h0000_0000
`define UV32_FF		32'hFFFF_FFFF

`define UV64_00		64'h0000_0000_0000_0000
`define UV64_FF		64'hFFFF_FFFF_FFFF_FFFF

`endif

// ==== src/ExAluW.sv ====
// Registered 64-bit ALU; operation in idUIxt[2:0], codes 6 and 7 give zero, SLT compares as signed.
`timescale 1ns/100ps

`include "ExUnit_defs.svh"

module ExAluW
(
	input  logic                   clock,
	input  logic                   reset,
	input  logic [`EX_DATA_W-1:0]  valRs,
	input  logic [`EX_DATA_W-1:0]  valRt,
	input  logic [7:0]             idUIxt,
	input  logic                   exHold,
	output logic [`EX_DATA_W-1:0]  valRn
);

	import ExPkg::*;

	exAluOp_t               aluOp;
	logic                   isLess;
	logic [`EX_DATA_W-1:0]  aluNext;
	logic [`EX_DATA_W-1:0]  aluReg;

	// ~~~~~~~~~~~~~~~~~~~~
	// Operation decode
	// ~~~~~~~~~~~~~~~~~~~~

	assign aluOp  = exAluOp_t'(idUIxt[2:0]);
	assign isLess = $signed(valRs) < $signed(valRt);

	always_comb
	begin
		case (aluOp)
			ALU_ADD:
				aluNext = valRs + valRt;
			ALU_SUB:
				aluNext = valRs - valRt;
			ALU_AND:
				aluNext = valRs & valRt;
			ALU_OR:
				aluNext = valRs | valRt;
			ALU_XOR:
				aluNext = valRs ^ valRt;
			ALU_SLT:
				aluNext = {{(`EX_DATA_W-1){1'b0}}, isLess};
			default:
				aluNext = `UV64_00;
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// Result register
	// ~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			aluReg <= `UV64_00;
		end
		else if (!exHold)
		begin
			aluReg <= aluNext;	// Held while the pipeline stalls.
		end
	end

	assign valRn = aluReg;

endmodule

// ==== src/ExMulW.sv ====
// Four-lane 16x16 multiply; mode idUIxt[4:1], unsigned if idUIxt[0], packed after the register.
`timescale 1ns/100ps

`include "ExUnit_defs.svh"

module ExMulW
(
	input  logic                   clock,
	input  logic                   reset,
	input  logic [`EX_DATA_W-1:0]  valRs,
	input  logic [`EX_DATA_W-1:0]  valRt,
	input  logic [7:0]             idUIxt,
	input  logic                   exHold,
	output logic [`EX_DATA_W-1:0]  valRn
);

	import ExPkg::*;

	logic              isUnsigned;
	logic [3:0][31:0]  rsExt;
	logic [3:0][31:0]  rtExt;

	logic [3:0][31:0]  prodReg;
	logic [3:0]        modeReg;
	logic              unsignedReg;

	// ~~~~~~~~~~~~~~~~~~~~
	// Lane split and extension
	// ~~~~~~~~~~~~~~~~~~~~

	assign isUnsigned = idUIxt[0];

	always_comb
	begin
		for (int i = 0; i < 4; i++)
		begin
			rsExt[i] = {(valRs[16*i+15] && !isUnsigned) ? `UV16_FF : `UV16_00,
				valRs[16*i +: 16]};
			rtExt[i] = {(valRt[16*i+15] && !isUnsigned) ? `UV16_FF : `UV16_00,
				valRt[16*i +: 16]};
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// Product and code registers
	// ~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clock)
	begin
		if (!exHold)
		begin
			for (int i = 0; i < 4; i++)
			begin
				prodReg[i] <= rsExt[i] * rtExt[i];	// Low 32 bits are exact for both signs.
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			modeReg     <= 4'h0;
			unsignedReg <= 1'b0;
		end
		else if (!exHold)
		begin
			modeReg     <= idUIxt[4:1];
			unsignedReg <= isUnsigned;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// Result packing
	// ~~~~~~~~~~~~~~~~~~~~

	always_comb
	begin
		case (exMulMode_t'(modeReg))
			MULW_LANE0:
				valRn = {(prodReg[0][31] && !unsignedReg) ? `UV32_FF : `UV32_00,
					prodReg[0]};
			MULW_LANE10:
				valRn = {prodReg[1], prodReg[0]};
			MULW_LOW4:
				valRn = {
					prodReg[3][15:0],
					prodReg[2][15:0],
					prodReg[1][15:0],
					prodReg[0][15:0]};
			MULW_HIGH4:
				valRn = {
					prodReg[3][31:16],
					prodReg[2][31:16],
					prodReg[1][31:16],
					prodReg[0][31:16]};
			default:
				valRn = `UV64_00;		// Unused packing codes.
		endcase
	end

endmodule

// ==== src/ExPkg.sv ====
// Command and extension encodings for the execute stage; unlisted codes decode to a zero result.
package ExPkg;

	// ~~~~~~~~~~~~~~~~~~~~
	// Unit command
	// ~~~~~~~~~~~~~~~~~~~~

	typedef enum logic [7:0]
	{
		UCMD_NONE  = 8'h00,
		UCMD_ALU   = 8'h01,
		UCMD_SHIFT = 8'h02,
		UCMD_MULW  = 8'h03
	} exUCmd_t;

	// ~~~~~~~~~~~~~~~~~~~~
	// Per-unit extension codes
	// ~~~~~~~~~~~~~~~~~~~~

	typedef enum logic [2:0]
	{
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4,
		ALU_SLT = 3'd5		// Signed compare, result in bit 0.
	} exAluOp_t;

	typedef enum logic [1:0]
	{
		SH_SHL = 2'd0,
		SH_SHR = 2'd1,
		SH_SAR = 2'd2
	} exShOp_t;

	typedef enum logic [3:0]
	{
		MULW_LANE0  = 4'd1,	// Lane 0 product, extended to 64 bits.
		MULW_LANE10 = 4'd3,
		MULW_LOW4   = 4'd4,
		MULW_HIGH4  = 4'd5
	} exMulMode_t;

endpackage

// ==== src/ExShiftW.sv ====
// Registered 64-bit shifter; kind in idUIxt[1:0], amount is valRt[5:0], code 3 gives zero.
`timescale 1ns/100ps

`include "ExUnit_defs.svh"

module ExShiftW
(
	input  logic                   clock,
	input  logic                   reset,
	input  logic [`EX_DATA_W-1:0]  valRs,
	input  logic [`EX_DATA_W-1:0]  valRt,
	input  logic [7:0]             idUIxt,
	input  logic                   exHold,
	output logic [`EX_DATA_W-1:0]  valRn
);

	import ExPkg::*;

	exShOp_t                shOp;
	logic [5:0]             shAmt;
	logic [`EX_DATA_W-1:0]  signFill;
	logic [`EX_DATA_W-1:0]  shNext;
	logic [`EX_DATA_W-1:0]  shReg;

	assign shOp     = exShOp_t'(idUIxt[1:0]);
	assign shAmt    = valRt[5:0];
	assign signFill = valRs[63] ? `UV64_FF : `UV64_00;

	// ~~~~~~~~~~~~~~~~~~~~
	// Shift select
	// ~~~~~~~~~~~~~~~~~~~~

	always_comb
	begin
		case (shOp)
			SH_SHL:
				shNext = valRs << shAmt;
			SH_SHR:
				shNext = valRs >> shAmt;
			SH_SAR:
				shNext = (valRs >> shAmt) | (signFill & ~(`UV64_FF >> shAmt));	// Vacated bits take the sign.
			default:
				shNext = `UV64_00;
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// Result register
	// ~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			shReg <= `UV64_00;
		end
		else if (!exHold)
		begin
			shReg <= shNext;
		end
	end

	assign valRn = shReg;

endmodule

// ==== src/ExUnit.sv ====
// Execute stage top; one clock latency, exHold freezes every register, unknown commands give zero.
`timescale 1ns/100ps

`include "ExUnit_defs.svh"

module ExUnit
(
	input  logic                   clock,
	input  logic                   reset,
	input  logic [`EX_DATA_W-1:0]  valRs,
	input  logic [`EX_DATA_W-1:0]  valRt,
	input  ExPkg::exUCmd_t         idUCmd,
	input  logic [7:0]             idUIxt,
	input  logic                   exHold,
	output logic [`EX_DATA_W-1:0]  valRn
);

	import ExPkg::*;

	exUCmd_t                cmdReg;
	logic [`EX_DATA_W-1:0]  aluRn;
	logic [`EX_DATA_W-1:0]  shiftRn;
	logic [`EX_DATA_W-1:0]  mulRn;

	// ~~~~~~~~~~~~~~~~~~~~
	// Function units
	// ~~~~~~~~~~~~~~~~~~~~

	// All units see the same operands and compute every cycle.
	ExAluW alu0
	(
		.clock  (clock),
		.reset  (reset),
		.valRs  (valRs),
		.valRt  (valRt),
		.idUIxt (idUIxt),
		.exHold (exHold),
		.valRn  (aluRn)
	);

	ExShiftW shift0
	(
		.clock  (clock),
		.reset  (reset),
		.valRs  (valRs),
		.valRt  (valRt),
		.idUIxt (idUIxt),
		.exHold (exHold),
		.valRn  (shiftRn)
	);

	ExMulW mul0
	(
		.clock  (clock),
		.reset  (reset),
		.valRs  (valRs),
		.valRt  (valRt),
		.idUIxt (idUIxt),
		.exHold (exHold),
		.valRn  (mulRn)
	);

	// ~~~~~~~~~~~~~~~~~~~~
	// Command register
	// ~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			cmdReg <= UCMD_NONE;	// Forces a zero result until the first operation.
		end
		else if (!exHold)
		begin
			cmdReg <= idUCmd;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// Result select
	// ~~~~~~~~~~~~~~~~~~~~

	always_comb
	begin
		case (cmdReg)
			UCMD_ALU:
				valRn = aluRn;
			UCMD_SHIFT:
				valRn = shiftRn;
			UCMD_MULW:
				valRn = mulRn;
			default:
				valRn = `UV64_00;	// NONE and undefined commands.
		endcase
	end

endmodule

// ==== include/tbExModel.svh ====
// Expected valRn for one taken operation; include inside a module body after importing ExPkg.
`ifndef TB_EX_MODEL_SVH
`define TB_EX_MODEL_SVH

// ~~~~~~~~~~~~~~~~~~~~
// Unit models
// ~~~~~~~~~~~~~~~~~~~~

function automatic logic [63:0] modelAlu(input logic [63:0] rs, input logic [63:0] rt,
	input logic [2:0] op);
	logic [63:0] res;
	case (op)
		3'd0: res = rs + rt;
		3'd1: res = rs - rt;
		3'd2: res = rs & rt;
		3'd3: res = rs | rt;
		3'd4: res = rs ^ rt;
		3'd5:
		begin
			if (rs[63] != rt[63])
				res = {63'd0, rs[63]};		// The negative operand is the smaller one.
			else
				res = {63'd0, rs < rt};
		end
		default: res = 64'd0;
	endcase
	return res;
endfunction

function automatic logic [63:0] modelShift(input logic [63:0] rs, input logic [63:0] rt,
	input logic [1:0] kind);
	logic signed [63:0] srs;
	logic [63:0] res;
	srs = rs;
	case (kind)
		2'd0: res = rs << rt[5:0];
		2'd1: res = rs >> rt[5:0];
		2'd2: res = srs >>> rt[5:0];
		default: res = 64'd0;
	endcase
	return res;
endfunction

function automatic logic [31:0] laneProduct(input logic [15:0] a, input logic [15:0] b,
	input logic isUns);
	longint wa;
	longint wb;
	longint prod;
	if (isUns)
	begin
		wa = a;
		wb = b;
	end
	else
	begin
		wa = $signed(a);
		wb = $signed(b);
	end
	prod = wa * wb;
	return prod[31:0];
endfunction

function automatic logic [63:0] modelMul(input logic [63:0] rs, input logic [63:0] rt,
	input logic [7:0] ixt);
	logic [31:0] p [4];
	logic [63:0] res;
	for (int i = 0; i < 4; i++)
		p[i] = laneProduct(rs[16*i +: 16], rt[16*i +: 16], ixt[0]);
	case (ixt[4:1])
		4'd1: res = ixt[0] ? {32'd0, p[0]} : {{32{p[0][31]}}, p[0]};
		4'd3: res = {p[1], p[0]};
		4'd4: res = {p[3][15:0], p[2][15:0], p[1][15:0], p[0][15:0]};
		4'd5: res = {p[3][31:16], p[2][31:16], p[1][31:16], p[0][31:16]};
		default: res = 64'd0;
	endcase
	return res;
endfunction

function automatic logic [63:0] expectedResult(input logic [7:0] cmd, input logic [63:0] rs,
	input logic [63:0] rt, input logic [7:0] ixt);
	case (cmd)
		8'd1: return modelAlu(rs, rt, ixt[2:0]);
		8'd2: return modelShift(rs, rt, ixt[1:0]);
		8'd3: return modelMul(rs, rt, ixt);
		default: return 64'd0;
	endcase
endfunction

`endif

// ==== tb/tbExUnit.sv ====
// Checks valRn on every falling edge against the model of the last taken operation; fixed seed.
`timescale 1ns/100ps

`include "ExUnit_defs.svh"

module tbExUnit;

	import ExPkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int NUM_VEC = 64;
	localparam int TOTAL_CYCLES = 5 + NUM_VEC * 10 + 1 + 2 * 6;	// Hold test takes up to 5 per op.

	logic clock;
	logic reset;
	logic [`EX_DATA_W-1:0] valRs;
	logic [`EX_DATA_W-1:0] valRt;
	exUCmd_t idUCmd;
	logic [7:0] idUIxt;
	logic exHold;
	logic [`EX_DATA_W-1:0] valRn;

	logic [7:0] takenCmd;
	logic [63:0] takenRs;
	logic [63:0] takenRt;
	logic [7:0] takenIxt;
	logic [63:0] expVal;
	logic expValid = 1'b0;
	string testName;
	string expName;
	int errorCount = 0;
	int passCount = 0;
	int failCount = 0;
	int unsigned seedValue;

	`include "tbExModel.svh"

	ExUnit dut0
	(
		.clock  (clock),
		.reset  (reset),
		.valRs  (valRs),
		.valRt  (valRt),
		.idUCmd (idUCmd),
		.idUIxt (idUIxt),
		.exHold (exHold),
		.valRn  (valRn)
	);

	initial
	begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// Expected value and checks
	// ~~~~~~~~~~~~~~~~~~~~

	always @(posedge clock)
	begin
		if (reset)
			takenCmd <= 8'h00;
		else if (!exHold)
		begin
			takenCmd <= idUCmd;
			takenRs <= valRs;
			takenRt <= valRt;
			takenIxt <= idUIxt;
		end
		expName <= testName;
		expValid <= 1'b1;
	end

	assign expVal = expectedResult(takenCmd, takenRs, takenRt, takenIxt);

	always @(negedge clock)
	begin
		if (expValid)
		begin
			assert (valRn === expVal)
			else
			begin
				errorCount++;
				$display("FAILED %s: expected %h, actual %h", expName, expVal, valRn);
			end
		end
	end

	initial
	begin
		#((TOTAL_CYCLES + 200) * CLK_PERIOD);
		$display("Run timed out before all tests finished.");
		$display("SOME TESTS FAILED");
		$finish;
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// Stimulus helpers
	// ~~~~~~~~~~~~~~~~~~~~

	function automatic logic [63:0] randWord();
		return {$urandom, $urandom};
	endfunction

	task automatic applyInputs(input logic [7:0] cmd, input logic [63:0] rs,
		input logic [63:0] rt, input logic [7:0] ixt, input logic hold);
		@(negedge clock);
		idUCmd = exUCmd_t'(cmd);
		valRs = rs;
		valRt = rt;
		idUIxt = ixt;
		exHold = hold;
	endtask

	task automatic randomOp(output logic [7:0] cmd, output logic [63:0] rs,
		output logic [63:0] rt, output logic [7:0] ixt);
		cmd = $urandom_range(1, 3);
		rs = randWord();
		rt = randWord();
		ixt = $urandom_range(0, 255);
	endtask

	function automatic logic [63:0] mulOperand(input int i);
		logic [63:0] w;
		w = randWord();
		if (i % 2 == 1)
		begin
			for (int l = 0; l < 4; l++)
			begin
				case ($urandom_range(0, 2))
					0: w[16*l +: 16] = 16'h8000;
					1: w[16*l +: 16] = 16'hFFFF;
					default: ;
				endcase
			end
		end
		return w;
	endfunction

	task automatic reportTest(input int startErrors);
		@(posedge clock);
		@(negedge clock);
		#1;		// Lets the last check of this test finish first.
		if (errorCount == startErrors)
		begin
			passCount++;
			$display("Test %s passed", testName);
		end
		else
		begin
			failCount++;
			$display("Test %s failed with %0d mismatches", testName, errorCount - startErrors);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~
	// Tests
	// ~~~~~~~~~~~~~~~~~~~~

	initial
	begin
		logic [7:0] cmd;
		logic [63:0] rs;
		logic [63:0] rt;
		logic [7:0] ixt;
		int startErrors;
		int holdLen;
		int prevUnit;
		seedValue = $urandom(57314);
		reset = 1'b1;
		exHold = 1'b1;
		valRs = '0;
		valRt = '0;
		idUIxt = '0;
		idUCmd = UCMD_NONE;

		testName = "reset";
		startErrors = errorCount;
		for (int i = 0; i < 4; i++)
			applyInputs(8'd1, randWord(), randWord(), $urandom_range(0, 255), i[0]);
		@(negedge clock);
		reset = 1'b0;
		for (int i = 0; i < NUM_VEC; i++)
		begin
			cmd = (i % 2 == 0) ? 8'd0 : 8'($urandom_range(4, 255));	// NONE or unknown.
			applyInputs(cmd, randWord(), randWord(), $urandom_range(0, 255), 1'b0);
		end
		reportTest(startErrors);

		testName = "alu";
		startErrors = errorCount;
		for (int i = 0; i < NUM_VEC; i++)
		begin
			rs = randWord();
			rt = randWord();
			if (i % 4 == 1)
				rt[63] = ~rs[63];
			applyInputs(8'd1, rs, rt, {5'($urandom_range(0, 31)), 3'(i % 8)}, 1'b0);
		end
		reportTest(startErrors);

		testName = "shift";
		startErrors = errorCount;
		for (int i = 0; i < NUM_VEC; i++)
		begin
			rs = randWord();
			if ((i / 4) % 2 == 1)
				rs[63] = 1'b1;
			applyInputs(8'd2, rs, randWord(), {6'($urandom_range(0, 63)), 2'(i % 4)}, 1'b0);
		end
		reportTest(startErrors);

		testName = "mulw";
		startErrors = errorCount;
		for (int i = 0; i < NUM_VEC; i++)
		begin
			ixt = $urandom_range(0, 255);
			case (i % 4)
				0: ixt[4:1] = 4'd1;
				1: ixt[4:1] = 4'd3;
				2: ixt[4:1] = 4'd4;
				default: ixt[4:1] = 4'd5;
			endcase
			if (i % 16 == 15)
				ixt[4:1] = 4'($urandom_range(6, 15));
			ixt[0] = (i / 4) % 2;
			applyInputs(8'd3, mulOperand(i), mulOperand(i), ixt, 1'b0);
		end
		reportTest(startErrors);

		testName = "hold";
		startErrors = errorCount;
		for (int i = 0; i < NUM_VEC; i++)
		begin
			randomOp(cmd, rs, rt, ixt);
			applyInputs(cmd, rs, rt, ixt, 1'b0);
			holdLen = $urandom_range(1, 4);
			for (int h = 0; h < holdLen; h++)
			begin
				randomOp(cmd, rs, rt, ixt);
				applyInputs(cmd, rs, rt, ixt, 1'b1);
			end
		end
		randomOp(cmd, rs, rt, ixt);
		applyInputs(cmd, rs, rt, ixt, 1'b0);
		reportTest(startErrors);

		testName = "mix";
		startErrors = errorCount;
		prevUnit = 1;
		for (int i = 0; i < NUM_VEC; i++)
		begin
			prevUnit = ((prevUnit - 1 + $urandom_range(1, 2)) % 3) + 1;	// Never the same unit twice.
			applyInputs(8'(prevUnit), randWord(), randWord(), $urandom_range(0, 255), 1'b0);
		end
		reportTest(startErrors);

		$display("Tests passed: %0d, tests failed: %0d", passCount, failCount);
		if (failCount == 0 && errorCount == 0)
		begin
			$display("ALL TESTS PASSED");
		end
		else
		begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule
